//--- design/addArray_params.svh
`ifndef ADD_ARRAY_PARAMS_SVH
`define ADD_ARRAY_PARAMS_SVH

// datapath shape
`define ADD_WIDTH 16 // operand and sum bits, power of two
`define ADD_LANES 4 // lanes started together
`define ADD_SPEED 2 // serial (0) brent-kung (1) or sklansky (2)

// apb byte addresses
// lane registers sit 4 bytes apart from the base
`define ADD_ADDR_OPA 8'h00
`define ADD_ADDR_OPB 8'h10
`define ADD_ADDR_CTRL 8'h20 // carry-in per lane in the low bits
`define ADD_ADDR_STATUS 8'h24 // done in bit 0, sticky overflow in bits 4 up
`define ADD_ADDR_RES 8'h30

`define ADD_CTRL_START 8 // start bit of the control word

`endif

//--- design/addArrayPkg.sv
`default_nettype none
`include "addArray_params.svh"

package addArrayPkg;

	typedef logic [`ADD_WIDTH-1:0] dataWord; // operand or sum
	typedef logic [`ADD_LANES-1:0] laneMask; // one bit per lane
	typedef logic [7:0] apbAddr; // byte address
	typedef logic [31:0] apbData; // bus word

	// operands handed to one lane
	typedef struct packed {
		logic valid; // one cycle pulse
		dataWord a;
		dataWord b;
		logic carryIn;
	} laneReq;

	// registered lane output
	typedef struct packed {
		logic valid;
		dataWord sum; // a + b + carryIn, wraps
		logic overflow; // signed result out of range
	} laneRes;

endpackage

`default_nettype wire

//--- design/prefixAndOr.sv
`timescale 1ns/1ps
`default_nettype none

module prefixAndOr #(
	parameter int width = 16, // bit positions
	parameter int speed = 2 // serial (0) brent-kung (1) sklansky (2)
) (
	input wire logic [width-1:0] gIn, // bit generate
	input wire logic [width-1:0] pIn, // bit propagate
	output logic [width-1:0] gOut, // group generate from bit 0
	output logic [width-1:0] pOut // group propagate from bit 0
);

	localparam int depth = $clog2(width); // levels of a log tree

	if (speed == 2) begin : sklansky
		// every level doubles the solved span
		wire [width-1:0] gLvl [0:depth];
		wire [width-1:0] pLvl [0:depth];

		assign gLvl[0] = gIn;
		assign pLvl[0] = pIn;

		for (genvar l = 1; l <= depth; l++) begin : level
			localparam int span = 2 ** (l - 1); // half group size
			for (genvar i = 0; i < width; i++) begin : node
				if ((i / span) % 2 == 1) begin : black
					// upper half reads the top bit of the lower half
					localparam int src = (i / span) * span - 1;
					assign gLvl[l][i] = gLvl[l-1][i] | (pLvl[l-1][i] & gLvl[l-1][src]);
					assign pLvl[l][i] = pLvl[l-1][i] & pLvl[l-1][src];
				end else begin : white
					assign gLvl[l][i] = gLvl[l-1][i]; // pass through
					assign pLvl[l][i] = pLvl[l-1][i];
				end
			end
		end

		assign gOut = gLvl[depth];
		assign pOut = pLvl[depth];
	end else if (speed == 1) begin : brentKung
		// up sweep solves power of two groups
		// down sweep then fills in the bits in between
		wire [width-1:0] gLvl [0:2*depth-1];
		wire [width-1:0] pLvl [0:2*depth-1];

		if (width != 2 ** depth || width < 4) begin : badWidth
			$error("brent-kung prefix needs a power of two width of at least 4");
		end

		assign gLvl[0] = gIn;
		assign pLvl[0] = pIn;

		for (genvar l = 1; l < 2 * depth; l++) begin : level
			localparam int stride = (l <= depth) ? 2 ** l : 2 ** (2 * depth - l);
			localparam int reach = stride / 2; // distance to the partner node
			for (genvar i = 0; i < width; i++) begin : node
				localparam bit isUp = (l <= depth) && ((i + 1) % stride == 0);
				localparam bit isDown = (l > depth) && (i >= stride) &&
					((i + 1) % stride == reach);
				if (isUp || isDown) begin : black
					assign gLvl[l][i] = gLvl[l-1][i] | (pLvl[l-1][i] & gLvl[l-1][i-reach]);
					assign pLvl[l][i] = pLvl[l-1][i] & pLvl[l-1][i-reach];
				end else begin : white
					assign gLvl[l][i] = gLvl[l-1][i];
					assign pLvl[l][i] = pLvl[l-1][i];
				end
			end
		end

		assign gOut = gLvl[2*depth-1];
		assign pOut = pLvl[2*depth-1];
	end else begin : serial
		// plain ripple, width-1 nodes deep
		wire [width-1:0] gChain;
		wire [width-1:0] pChain;

		assign gChain[0] = gIn[0];
		assign pChain[0] = pIn[0];

		for (genvar i = 1; i < width; i++) begin : node
			assign gChain[i] = gIn[i] | (pIn[i] & gChain[i-1]);
			assign pChain[i] = pIn[i] & pChain[i-1];
		end

		assign gOut = gChain;
		assign pOut = pChain;
	end

endmodule

`default_nettype wire

//--- design/addV.sv
`timescale 1ns/1ps
`default_nettype none
`include "addArray_params.svh"

module addV #(
	parameter int width = `ADD_WIDTH,
	parameter int speed = `ADD_SPEED
) (
	input wire addArrayPkg::dataWord a,
	input wire addArrayPkg::dataWord b,
	input wire logic carryIn,
	output addArrayPkg::dataWord sum,
	output logic overflow // two's complement overflow
);

	logic [width-1:0] gBit; // prefix inputs
	logic [width-1:0] pBit;
	logic [width-1:0] halfSum; // a xor b
	logic [width-1:0] carry; // carry out of each bit

	if (width != $bits(addArrayPkg::dataWord)) begin : badWidth
		$error("addV width must match the data word");
	end

	// carry-in folded into bit 0 as a majority generate
	assign gBit = {a[width-1:1] & b[width-1:1], (a[0] & b[0]) | (a[0] & carryIn) | (b[0] & carryIn)};
	assign pBit = {a[width-1:1] | b[width-1:1], 1'b0}; // bit 0 never propagates
	assign halfSum = a ^ b;

	prefixAndOr #(
		.width(width),
		.speed(speed)
	) prefix (
		.gIn(gBit),
		.pIn(pBit),
		.gOut(carry),
		.pOut() // group propagate not needed for a plain sum
	);

	assign sum = halfSum ^ {carry[width-2:0], carryIn};
	assign overflow = carry[width-1] ^ carry[width-2]; // carry into msb vs out of msb

endmodule

`default_nettype wire

//--- design/adderLane.sv
`timescale 1ns/1ps
`default_nettype none
`include "addArray_params.svh"

module adderLane (
	input wire logic clk,
	input wire logic reset,
	input wire addArrayPkg::laneReq req,
	output addArrayPkg::laneRes res
);

	localparam int maxSigned = 2 ** (`ADD_WIDTH - 1) - 1;
	localparam int minSigned = -(2 ** (`ADD_WIDTH - 1));

	addArrayPkg::dataWord sumNext; // combinational adder output
	logic ovNext;
	logic resValid;
	addArrayPkg::dataWord resSum;
	logic resOverflow;
	logic signed [`ADD_WIDTH+1:0] refSum; // two guard bits, never wraps
	logic refOverflow;

	addV #(
		.width(`ADD_WIDTH),
		.speed(`ADD_SPEED)
	) adder (
		.a(req.a),
		.b(req.b),
		.carryIn(req.carryIn),
		.sum(sumNext),
		.overflow(ovNext)
	);

	always_ff @(posedge clk) begin
		if (reset) resValid <= 1'b0;
		else resValid <= req.valid; // one cycle behind the request
	end

	// result held until the next request
	always_ff @(posedge clk) begin
		if (req.valid) begin
			resSum <= sumNext;
			resOverflow <= ovNext;
		end
	end

	assign res = '{valid: resValid, sum: resSum, overflow: resOverflow};

	// wide signed reference for the flag check
	assign refSum = $signed(req.a) + $signed(req.b) + $signed({1'b0, req.carryIn});
	assign refOverflow = (refSum > maxSigned) || (refSum < minSigned);

	assert property (@(posedge clk) disable iff (reset)
		res.valid |-> res.overflow == $past(refOverflow))
		else $error("lane overflow flag disagrees with the signed range check");

	// feeder only ever sends single cycle starts
	assert property (@(posedge clk) disable iff (reset) res.valid |=> !res.valid)
		else $error("lane result valid held for two cycles");

endmodule

`default_nettype wire

//--- design/apbOperandFeeder.sv
`timescale 1ns/1ps
`default_nettype none
`include "addArray_params.svh"

module apbOperandFeeder (
	input wire logic clk,
	input wire logic reset,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire addArrayPkg::apbAddr paddr,
	input wire addArrayPkg::apbData pwdata,
	output addArrayPkg::apbData prdata,
	output logic pready,
	output addArrayPkg::laneReq laneReqs [`ADD_LANES],
	input wire addArrayPkg::dataWord results [`ADD_LANES],
	input wire logic done,
	input wire addArrayPkg::laneMask overflowFlags,
	output logic clearPulse, // status write strobe
	output addArrayPkg::laneMask clearMask
);

	addArrayPkg::dataWord opA [`ADD_LANES]; // operand a per lane
	addArrayPkg::dataWord opB [`ADD_LANES];
	addArrayPkg::apbData ctrlWord; // last control write, kept whole for readback
	logic reqValid; // start pulse to all lanes
	logic wrEn;
	logic rdEn;
	addArrayPkg::apbData statusWord;

	assign wrEn = psel && penable && pwrite; // access phase only
	assign rdEn = psel && penable && !pwrite;
	assign pready = 1'b1; // zero wait states

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `ADD_LANES; i++) begin
				opA[i] <= '0;
				opB[i] <= '0;
			end
			ctrlWord <= '0;
			reqValid <= 1'b0;
		end else begin
			reqValid <= 1'b0; // drops again after one cycle
			if (wrEn) begin
				for (int i = 0; i < `ADD_LANES; i++) begin
					if (paddr == addArrayPkg::apbAddr'(`ADD_ADDR_OPA + 4 * i))
						opA[i] <= pwdata[`ADD_WIDTH-1:0];
					if (paddr == addArrayPkg::apbAddr'(`ADD_ADDR_OPB + 4 * i))
						opB[i] <= pwdata[`ADD_WIDTH-1:0];
				end
				if (paddr == `ADD_ADDR_CTRL) begin
					ctrlWord <= pwdata;
					reqValid <= pwdata[`ADD_CTRL_START]; // start lanes next cycle
				end
			end
		end
	end

	// operands come straight from the registers
	// they cannot change before the lanes capture them
	for (genvar i = 0; i < `ADD_LANES; i++) begin : laneDrive
		assign laneReqs[i] = '{valid: reqValid, a: opA[i], b: opB[i], carryIn: ctrlWord[i]};
	end

	// write one to clear, decoded from the status layout
	assign clearPulse = wrEn && (paddr == `ADD_ADDR_STATUS);
	assign clearMask = pwdata[4 +: `ADD_LANES]; // sticky overflow bits

	always_comb begin
		statusWord = '0;
		statusWord[0] = done;
		statusWord[4 +: `ADD_LANES] = overflowFlags;
	end

	// read mux, zero outside the access phase
	always_comb begin
		prdata = '0;
		if (rdEn) begin
			for (int i = 0; i < `ADD_LANES; i++) begin
				if (paddr == addArrayPkg::apbAddr'(`ADD_ADDR_OPA + 4 * i))
					prdata = addArrayPkg::apbData'(opA[i]);
				if (paddr == addArrayPkg::apbAddr'(`ADD_ADDR_OPB + 4 * i))
					prdata = addArrayPkg::apbData'(opB[i]);
				if (paddr == addArrayPkg::apbAddr'(`ADD_ADDR_RES + 4 * i))
					prdata = addArrayPkg::apbData'(results[i]);
			end
			if (paddr == `ADD_ADDR_CTRL) prdata = ctrlWord;
			if (paddr == `ADD_ADDR_STATUS) prdata = statusWord;
		end
	end

	// apb master keeps psel through the access phase
	assert property (@(posedge clk) disable iff (reset) penable |-> psel)
		else $error("penable high without psel");

endmodule

`default_nettype wire

//--- design/resultCollector.sv
`timescale 1ns/1ps
`default_nettype none
`include "addArray_params.svh"

module resultCollector (
	input wire logic clk,
	input wire logic reset,
	input wire addArrayPkg::laneRes laneRess [`ADD_LANES],
	input wire logic clearPulse,
	input wire addArrayPkg::laneMask clearMask,
	output addArrayPkg::dataWord results [`ADD_LANES],
	output logic done,
	output addArrayPkg::laneMask overflowFlags // sticky per lane
);

	addArrayPkg::laneMask validVec; // lane valids side by side
	addArrayPkg::laneMask ovVec; // overflow seen this cycle
	addArrayPkg::laneMask clearBits;

	always_comb begin
		for (int i = 0; i < `ADD_LANES; i++) begin
			validVec[i] = laneRess[i].valid;
			ovVec[i] = laneRess[i].valid && laneRess[i].overflow;
		end
	end

	assign clearBits = clearPulse ? clearMask : '0;

	// stored sums read back as zero after reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `ADD_LANES; i++) results[i] <= '0;
		end else begin
			for (int i = 0; i < `ADD_LANES; i++) begin
				if (laneRess[i].valid) results[i] <= laneRess[i].sum;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			done <= 1'b0;
			overflowFlags <= '0;
		end else begin
			// fresh results set done again
			if (&validVec) done <= 1'b1;
			else if (clearBits[0]) done <= 1'b0; // lane 0 clear bit also acks done
			overflowFlags <= (overflowFlags & ~clearBits) | ovVec; // new overflow wins
		end
	end

	// lanes are started together and have equal latency
	assert property (@(posedge clk) disable iff (reset) (validVec == '0) || (&validVec))
		else $error("lane result valids out of step");

endmodule

`default_nettype wire

//--- design/addArrayTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "addArray_params.svh"

module addArrayTop (
	input wire logic clk,
	input wire logic reset,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire addArrayPkg::apbAddr paddr,
	input wire addArrayPkg::apbData pwdata,
	output addArrayPkg::apbData prdata,
	output logic pready
);

	addArrayPkg::laneReq laneReqs [`ADD_LANES]; // feeder to lanes
	addArrayPkg::laneRes laneRess [`ADD_LANES]; // lanes to collector
	addArrayPkg::dataWord results [`ADD_LANES]; // stored sums for readback
	logic done;
	addArrayPkg::laneMask overflowFlags;
	logic clearPulse;
	addArrayPkg::laneMask clearMask;

	apbOperandFeeder feeder (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.laneReqs(laneReqs),
		.results(results),
		.done(done),
		.overflowFlags(overflowFlags),
		.clearPulse(clearPulse),
		.clearMask(clearMask)
	);

	for (genvar i = 0; i < `ADD_LANES; i++) begin : lane
		adderLane adder (
			.clk(clk),
			.reset(reset),
			.req(laneReqs[i]),
			.res(laneRess[i])
		);
	end

	resultCollector collector (
		.clk(clk),
		.reset(reset),
		.laneRess(laneRess),
		.clearPulse(clearPulse),
		.clearMask(clearMask),
		.results(results),
		.done(done),
		.overflowFlags(overflowFlags)
	);

endmodule

`default_nettype wire

//--- sim/addArrayTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "addArray_params.svh"

module addArrayTb;

	localparam int readyLimit = 16; // access cycles allowed per transfer

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;

	int checks; // compares made
	int errors;
	logic timedOut; // a hung transfer stops the vector loop
	logic [3:0] stickyExp; // model of the sticky overflow mask
	logic doneExp;

	// one batch of vectors by lane
	logic [31:0] vecA [0:`ADD_LANES-1];
	logic [31:0] vecB [0:`ADD_LANES-1];
	logic [31:0] vecCin [0:`ADD_LANES-1];
	logic [31:0] vecSum [0:`ADD_LANES-1];
	logic [31:0] vecOv [0:`ADD_LANES-1];

	addArrayTop uut (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready)
	);

	always #50 clk = ~clk; // 100 ns period

	task automatic compareWord(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// setup then access then idle on falling edges
	task automatic apbTransfer(input logic write, input logic [7:0] addr,
			input logic [31:0] data, output logic [31:0] rdata);
		int waited;
		waited = 0;
		rdata = 32'h0;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		#1; // read mux settles on the access phase
		while (pready !== 1'b1 && waited < readyLimit) begin
			@(negedge clk); // slave stretches the access phase
			#1;
			waited++;
		end
		if (pready !== 1'b1) begin
			$display("ERROR: pready never asserted, transfer to address %h", addr);
			errors++;
			timedOut = 1'b1;
		end
		rdata = prdata; // held until the access edge
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		apbTransfer(1'b1, addr, data, unused);
	endtask

	task automatic apbRead(input logic [7:0] addr, output logic [31:0] data);
		apbTransfer(1'b0, addr, 32'h0, data);
	endtask

	// sticky clear mask per batch
	// bit 0 also acks done
	function automatic logic [3:0] clearMaskFor(input int batch);
		case (batch % 5)
			2: return 4'h5;
			3: return 4'h3;
			4: return 4'hf;
			default: return 4'h1; // keeps lanes 1 to 3 set
		endcase
	endfunction

	task automatic runBatch(input int batch);
		logic [31:0] rdata;
		logic [31:0] ctrl;
		logic [3:0] mask;
		logic [3:0] batchOv;
		ctrl = 32'h0;
		batchOv = 4'h0;
		for (int i = 0; i < `ADD_LANES; i++) begin
			apbWrite(8'(`ADD_ADDR_OPA + 4 * i), vecA[i]);
			apbWrite(8'(`ADD_ADDR_OPB + 4 * i), vecB[i]);
			ctrl[i] = vecCin[i][0];
			batchOv[i] = vecOv[i][0];
		end
		for (int i = 0; i < `ADD_LANES; i++) begin
			apbRead(8'(`ADD_ADDR_OPA + 4 * i), rdata);
			compareWord($sformatf("opA[%0d]", i), vecA[i], rdata);
			apbRead(8'(`ADD_ADDR_OPB + 4 * i), rdata);
			compareWord($sformatf("opB[%0d]", i), vecB[i], rdata);
		end
		mask = clearMaskFor(batch);
		apbWrite(`ADD_ADDR_STATUS, {24'h0, mask, 4'h0}); // write one to clear
		stickyExp = stickyExp & ~mask;
		if (mask[0]) doneExp = 1'b0;
		apbRead(`ADD_ADDR_STATUS, rdata);
		compareWord("status after clear", {24'h0, stickyExp, 3'b000, doneExp}, rdata);
		ctrl[`ADD_CTRL_START] = 1'b1;
		apbWrite(`ADD_ADDR_CTRL, ctrl);
		stickyExp = stickyExp | batchOv; // overflow rule from the file column
		doneExp = 1'b1;
		apbRead(`ADD_ADDR_STATUS, rdata); // first read after the start
		compareWord("status after start", {24'h0, stickyExp, 3'b000, doneExp}, rdata);
		for (int i = 0; i < `ADD_LANES; i++) begin
			apbRead(8'(`ADD_ADDR_RES + 4 * i), rdata);
			compareWord($sformatf("result[%0d]", i), vecSum[i], rdata);
		end
		apbRead(`ADD_ADDR_CTRL, rdata);
		compareWord("ctrl", ctrl, rdata);
	endtask

	initial begin : main
		int fd;
		int fields;
		int lane;
		int batch;
		int got;
		string line;
		logic [31:0] rdata;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] cin;
		logic [31:0] sum;
		logic [31:0] ov;
		logic [`ADD_LANES-1:0] loaded; // lanes filled in the current batch
		clk = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h0;
		pwdata = 32'h0;
		checks = 0;
		errors = 0;
		timedOut = 1'b0;
		stickyExp = 4'h0;
		doneExp = 1'b0;
		batch = 0;
		loaded = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// everything reads zero out of reset
		apbRead(`ADD_ADDR_STATUS, rdata);
		compareWord("status after reset", 32'h0, rdata);
		apbRead(`ADD_ADDR_CTRL, rdata);
		compareWord("ctrl after reset", 32'h0, rdata);
		for (int i = 0; i < `ADD_LANES; i++) begin
			apbRead(8'(`ADD_ADDR_RES + 4 * i), rdata);
			compareWord($sformatf("result[%0d] after reset", i), 32'h0, rdata);
			apbRead(8'(`ADD_ADDR_OPA + 4 * i), rdata);
			compareWord($sformatf("opA[%0d] after reset", i), 32'h0, rdata);
		end

		fd = $fopen("sim/addArray_stimulus.txt", "r");
		if (fd == 0) begin
			$display("ERROR: could not open the stimulus file sim/addArray_stimulus.txt");
			errors++;
		end else begin
			while (!$feof(fd) && !timedOut) begin
				line = "";
				got = $fgets(line, fd);
				if (got == 0 || line.len() < 2 || line.getc(0) == "#") continue; // comments
				fields = $sscanf(line, "%h %h %h %h %h %h", lane, a, b, cin, sum, ov);
				if (fields != 6 || lane < 0 || lane >= `ADD_LANES) begin
					$display("ERROR: malformed stimulus line: %s", line);
					errors++;
				end else begin
					vecA[lane] = a;
					vecB[lane] = b;
					vecCin[lane] = cin;
					vecSum[lane] = sum;
					vecOv[lane] = ov;
					loaded[lane] = 1'b1;
					if (&loaded) begin // full batch runs on all lanes together
						runBatch(batch);
						batch++;
						loaded = '0;
					end
				end
			end
			$fclose(fd);
			if (batch == 0) begin
				$display("ERROR: the stimulus file held no complete batch of vectors");
				errors++;
			end
			if (loaded != '0) begin
				$display("ERROR: the stimulus file ends with an incomplete batch");
				errors++;
			end
		end

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/addArray_stimulus.txt
# columns in hex: lane a b carryIn expectedSum expectedOverflow
# four lines make one batch, started together
0 0001 0002 0 0003 0
1 1234 4321 1 5556 0
2 7fff 0001 0 8000 1
3 ffff ffff 1 ffff 0
0 8000 ffff 0 7fff 1
1 7ffe 0001 1 8000 1
2 ffff 0001 0 0000 0
3 0000 0000 0 0000 0
0 8000 8000 0 0000 1
1 00ff ff01 0 0000 0
2 4000 4000 0 8000 1
3 c000 c000 0 8000 0
0 7fff 7fff 1 ffff 1
1 8000 7fff 1 0000 0
2 5555 aaaa 0 ffff 0
3 8001 fffe 1 8000 0
0 0000 0000 1 0001 0
1 8000 8000 1 0001 1
2 3a5c 1b2d 0 5589 0
3 ffff 8000 0 7fff 1

//--- files.f
+incdir+design
design/addArrayPkg.sv
design/prefixAndOr.sv
design/addV.sv
design/adderLane.sv
design/apbOperandFeeder.sv
design/resultCollector.sv
design/addArrayTop.sv
sim/addArrayTb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
	-f files.f \
	--top-module addArrayTb \
	-Mdir obj_dir \
	-o addArraySim

./obj_dir/addArraySim > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi

echo "simulation passed"
